// ==== filelist.f ====
logic/fetch_pkg.sv
logic/fill_pkg.sv
logic/bypass_port_fsm.sv
logic/bypass_req_arbiter.sv
logic/bypass_rsp_tracker.sv
logic/icache_bypass.sv
tb/icache_bypass_properties.sv
tb/icache_bypass_tb.sv

// ==== Makefile ====
# Verilator simulation of the uncached instruction-fetch path

VERILATOR ?= verilator
TOP       ?= icache_bypass_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= Test completed successfully

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) $(SIM_ARGS) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tb/icache_bypass_tb.sv ====
// Testbench for the uncached instruction-fetch path.
// Directed and random fetches on all ports run against a fill memory
// model, and every returned word and error bit is checked against a model.
`default_nettype none

module icache_bypass_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import fetch_pkg::*;
  import fill_pkg::*;

  localparam int NR_PORTS      = 4;
  localparam int FIFO_DEPTH    = 2;
  localparam int RESET_CYCLES  = 5;
  localparam int MAX_JOBS      = 16;
  localparam int RAND_JOBS     = 12;
  localparam int TOTAL_FETCHES = 4 + 2 * NR_PORTS * RAND_JOBS + 2 * NR_PORTS;
  localparam fetch_word_t DATA_XOR = 32'hA5C3_5A3C;

  logic                       clk;
  logic                       arst_n;
  logic        [NR_PORTS-1:0] inst_valid;
  addr_t       [NR_PORTS-1:0] inst_addr;
  logic        [NR_PORTS-1:0] inst_ready;
  fetch_word_t [NR_PORTS-1:0] inst_data;
  logic        [NR_PORTS-1:0] inst_error;
  logic                       fill_req_valid;
  addr_t                      fill_req_addr;
  logic                       fill_req_ready;
  logic                       fill_rsp_valid;
  line_t                      fill_rsp_data;
  logic                       fill_rsp_error;

  // Core model of each port
  addr_t job_addr [NR_PORTS][MAX_JOBS];
  addr_t cur_addr [NR_PORTS];
  int    job_cnt  [NR_PORTS];
  int    job_pos  [NR_PORTS];
  int    gap      [NR_PORTS];
  logic  busy     [NR_PORTS];
  logic  hold     [NR_PORTS];

  // Lines accepted by the fill model, their due cycles, and lines not yet requested
  addr_t fill_q [$];
  int    due_q  [$];
  addr_t want_q [$];

  logic [31:0] rng_state;
  logic        stall_en;
  logic        gaps_en;
  int          cycle = 0;
  int          fetches = 0;
  int          completions = 0;
  int          xfers = 0;
  int          rsps = 0;
  int          checks = 0;
  int          errors = 0;
  int          tests_run = 0;
  int          tests_bad = 0;

  icache_bypass #(
    .NR_FETCH_PORTS ( NR_PORTS   ),
    .RSP_FIFO_DEPTH ( FIFO_DEPTH )
  ) u_icache_bypass (
    .clk_i            ( clk            ),
    .arst_n_i         ( arst_n         ),
    .inst_valid_i     ( inst_valid     ),
    .inst_addr_i      ( inst_addr      ),
    .inst_ready_o     ( inst_ready     ),
    .inst_data_o      ( inst_data      ),
    .inst_error_o     ( inst_error     ),
    .fill_req_valid_o ( fill_req_valid ),
    .fill_req_addr_o  ( fill_req_addr  ),
    .fill_req_ready_i ( fill_req_ready ),
    .fill_rsp_valid_i ( fill_rsp_valid ),
    .fill_rsp_data_i  ( fill_rsp_data  ),
    .fill_rsp_error_i ( fill_rsp_error )
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // A fetch never needs more than 40 cycles, even behind all other ports
  initial begin
    repeat (RESET_CYCLES + TOTAL_FETCHES * 40) @(posedge clk);
    $display("Watchdog expired after %0d cycles with fetches still open", cycle);
    $display("Test failed");
    $finish;
  end

  function automatic int unsigned rand_below(int unsigned n);
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return (rng_state >> 8) % n;
  endfunction

  function automatic addr_t line_align(addr_t a);
    return a & ~addr_t'(LINE_WIDTH / 8 - 1);
  endfunction

  // Word k of the line at A holds A + 4k, scrambled by a fixed pattern
  function automatic line_t build_line(addr_t a);
    line_t line;
    for (int k = 0; k < LINE_WIDTH / FETCH_DW; k++) begin
      line[k*FETCH_DW +: FETCH_DW] = (a + addr_t'(4 * k)) ^ DATA_XOR;
    end
    return line;
  endfunction

  function automatic fetch_word_t expect_word(addr_t a);
    int unsigned word_idx;
    word_idx = (a % (LINE_WIDTH / 8)) / (FETCH_DW / 8);
    return (line_align(a) + addr_t'(4 * word_idx)) ^ DATA_XOR;
  endfunction

  function automatic logic expect_error(addr_t a);
    return a[12];
  endfunction

  // Few distinct lines so that ports often share one
  function automatic addr_t rand_addr();
    addr_t a;
    a      = 32'h8000_0000;
    a[12]  = 1'(rand_below(2));
    a[7:4] = 4'(rand_below(16));
    a[3:2] = 2'(rand_below(4));
    return a;
  endfunction

  function automatic logic all_idle();
    for (int p = 0; p < NR_PORTS; p++) begin
      if (busy[p] || hold[p] || job_pos[p] < job_cnt[p]) begin
        return 1'b0;
      end
    end
    return fill_q.size() == 0;
  endfunction

  task automatic check_word(string name, fetch_word_t got, fetch_word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_bit(string name, logic got, logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_addr(string name, addr_t got, addr_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic flag_error(string msg);
    errors++;
    $display("Error at %0t: %s", $time, msg);
  endtask

  // Each falling edge runs the fill model first and then every port's core
  task automatic cycle_step();
    logic [NR_PORTS-1:0] ready_now;
    logic                req_valid_now;
    addr_t               req_addr_now;
    int                  match;
    ready_now     = inst_ready;
    req_valid_now = fill_req_valid;
    req_addr_now  = fill_req_addr;
    cycle++;
    fill_rsp_valid = 1'b0;
    if (fill_q.size() > 0 && due_q[0] <= cycle) begin
      fill_rsp_valid = 1'b1;
      fill_rsp_data  = build_line(fill_q[0]);
      fill_rsp_error = fill_q[0][12];
      void'(fill_q.pop_front());
      void'(due_q.pop_front());
      rsps++;
    end
    fill_req_ready = stall_en ? (rand_below(3) != 0) : 1'b1;
    if (req_valid_now && fill_req_ready) begin
      match = -1;
      foreach (want_q[i]) begin
        if (match < 0 && want_q[i] == req_addr_now) begin
          match = i;
        end
      end
      if (match >= 0) begin
        want_q.delete(match);
      end else if (want_q.size() > 0) begin
        check_addr("fill_req_addr_o", req_addr_now, want_q[0]);
      end else begin
        flag_error("fill request issued while no fetch was waiting for a line");
      end
      fill_q.push_back(req_addr_now);
      due_q.push_back(cycle + 1 + int'(rand_below(4)));
      xfers++;
      if (xfers - rsps > FIFO_DEPTH) begin
        flag_error("more fills outstanding than the order FIFO can hold");
      end
    end
    for (int p = 0; p < NR_PORTS; p++) begin
      if (ready_now[p]) begin
        if (busy[p]) begin
          check_word($sformatf("inst_data_o[%0d]", p), inst_data[p], expect_word(cur_addr[p]));
          check_bit($sformatf("inst_error_o[%0d]", p), inst_error[p], expect_error(cur_addr[p]));
          busy[p] = 1'b0;
          hold[p] = 1'b1;
          completions++;
        end else begin
          flag_error($sformatf("port %0d raised inst_ready_o with no fetch pending", p));
        end
      end else if (!busy[p]) begin
        // Valid stays up through the ready cycle, then a new fetch may follow
        if (hold[p]) begin
          hold[p] = 1'b0;
          gap[p]  = gaps_en ? int'(rand_below(4)) : 0;
        end
        if (gap[p] > 0) begin
          gap[p]--;
          inst_valid[p] = 1'b0;
        end else if (job_pos[p] < job_cnt[p]) begin
          cur_addr[p] = job_addr[p][job_pos[p]];
          job_pos[p]++;
          inst_valid[p] = 1'b1;
          inst_addr[p]  = cur_addr[p];
          busy[p]       = 1'b1;
          want_q.push_back(line_align(cur_addr[p]));
          fetches++;
        end else begin
          inst_valid[p] = 1'b0;
        end
      end
    end
  endtask

  task automatic report_test(string name, int err_start, int n);
    tests_run++;
    if (errors != err_start) begin
      tests_bad++;
      $display("%s: FAIL with %0d errors", name, errors - err_start);
    end else begin
      $display("%s: PASS, %0d fetches", name, n);
    end
  endtask

  task automatic run_test(string name);
    int err_start;
    int fetch_start;
    int done_start;
    int xfer_start;
    err_start   = errors;
    fetch_start = fetches;
    done_start  = completions;
    xfer_start  = xfers;
    job_pos     = '{default: 0};
    do begin
      @(negedge clk);
      cycle_step();
    end while (!all_idle());
    if (completions - done_start != fetches - fetch_start) begin
      flag_error("number of completed fetches differs from fetches issued");
    end
    if (xfers - xfer_start != fetches - fetch_start || want_q.size() != 0) begin
      flag_error("number of fill requests differs from number of fetches");
    end
    report_test(name, err_start, fetches - fetch_start);
  endtask

  task automatic load_random(int count);
    for (int p = 0; p < NR_PORTS; p++) begin
      for (int j = 0; j < count; j++) begin
        job_addr[p][j] = rand_addr();
      end
      job_cnt[p] = count;
    end
  endtask

  initial begin
    int err_start;
    rng_state      = 32'd73;
    arst_n         = 1'b0;
    inst_valid     = '0;
    inst_addr      = '0;
    fill_req_ready = 1'b0;
    fill_rsp_valid = 1'b0;
    fill_rsp_data  = '0;
    fill_rsp_error = 1'b0;
    stall_en       = 1'b0;
    gaps_en        = 1'b0;
    busy           = '{default: 1'b0};
    hold           = '{default: 1'b0};
    gap            = '{default: 0};
    job_cnt        = '{default: 0};
    job_pos        = '{default: 0};
    repeat (RESET_CYCLES) @(negedge clk);
    arst_n = 1'b1;

    err_start = errors;
    repeat (4) begin
      @(negedge clk);
      check_bit("fill_req_valid_o", fill_req_valid, 1'b0);
      for (int p = 0; p < NR_PORTS; p++) begin
        check_bit($sformatf("inst_ready_o[%0d]", p), inst_ready[p], 1'b0);
      end
    end
    report_test("reset_idle", err_start, 0);

    for (int j = 0; j < 4; j++) begin
      job_addr[0][j] = 32'h0000_2340 + addr_t'(4 * j);
    end
    job_cnt[0] = 4;
    run_test("single_port_offsets");

    gaps_en = 1'b1;
    load_random(RAND_JOBS);
    run_test("random_concurrent");

    stall_en = 1'b1;
    load_random(RAND_JOBS);
    run_test("fill_stalls");

    // Alternate bit 12 between neighbouring ports and fetches
    stall_en = 1'b0;
    for (int p = 0; p < NR_PORTS; p++) begin
      for (int j = 0; j < 2; j++) begin
        job_addr[p][j] = 32'h0040_0000 | addr_t'(((p + j) % 2) << 12) | addr_t'(p * 16 + j * 4);
      end
      job_cnt[p] = 2;
    end
    run_test("error_bit");

    $display("Tests run %0d, failing %0d, checks %0d, errors %0d, assertion failures %0d",
             tests_run, tests_bad, checks, errors, u_icache_bypass.u_properties.fail_count);
    if (errors == 0 && u_icache_bypass.u_properties.fail_count == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb/icache_bypass_properties.sv ====
// Handshake assertions for the uncached fetch path.
// Checks fill request stability and alignment, single-cycle fetch
// responses and the limit on outstanding fills.
`default_nettype none

module icache_bypass_properties #(
  parameter int unsigned NR_FETCH_PORTS = 4,
  parameter int unsigned RSP_FIFO_DEPTH = 2
) (
  input logic                      clk_i,
  input logic                      arst_n_i,
  input logic [NR_FETCH_PORTS-1:0] inst_ready_o,
  input logic                      fill_req_valid_o,
  input fetch_pkg::addr_t          fill_req_addr_o,
  input logic                      fill_req_ready_i,
  input logic                      fill_rsp_valid_i
);

  timeunit 1ns;
  timeprecision 1ps;

  import fill_pkg::*;

  int unsigned fail_count = 0;
  int          outstanding;

  // Fills accepted and not yet answered
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      outstanding <= 0;
    end else begin
      outstanding <= outstanding + int'(fill_req_valid_o && fill_req_ready_i)
                     - int'(fill_rsp_valid_i);
    end
  end

  req_hold_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    fill_req_valid_o && !fill_req_ready_i |=> fill_req_valid_o && $stable(fill_req_addr_o))
  else begin
    $error("stalled fill request dropped or changed its address");
    fail_count++;
  end

  for (genvar i = 0; i < NR_FETCH_PORTS; i++) begin : gen_ready
    ready_pulse_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      inst_ready_o[i] |=> !inst_ready_o[i])
    else begin
      $error("inst_ready_o of port %0d held for more than one cycle", i);
      fail_count++;
    end
  end

  fill_limit_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    outstanding <= int'(RSP_FIFO_DEPTH))
  else begin
    $error("%0d fills outstanding", outstanding);
    fail_count++;
  end

  req_aligned_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    fill_req_valid_o |-> fill_req_addr_o[LINE_ALIGN-1:0] == '0)
  else begin
    $error("fill request address 0x%h is not line aligned", fill_req_addr_o);
    fail_count++;
  end

endmodule

bind icache_bypass icache_bypass_properties #(
  .NR_FETCH_PORTS ( NR_FETCH_PORTS ),
  .RSP_FIFO_DEPTH ( RSP_FIFO_DEPTH )
) u_properties (
  .clk_i            ( clk_i            ),
  .arst_n_i         ( arst_n_i         ),
  .inst_ready_o     ( inst_ready_o     ),
  .fill_req_valid_o ( fill_req_valid_o ),
  .fill_req_addr_o  ( fill_req_addr_o  ),
  .fill_req_ready_i ( fill_req_ready_i ),
  .fill_rsp_valid_i ( fill_rsp_valid_i )
);

`default_nettype wire

// ==== logic/icache_bypass.sv ====
// Uncached instruction-fetch path of the instruction cache.
// Several fetch ports share one fill port through a round-robin request
// arbiter and an order FIFO that returns each line to its port.
`default_nettype none

module icache_bypass #(
  parameter int unsigned NR_FETCH_PORTS = 4,
  parameter int unsigned RSP_FIFO_DEPTH = 2
) (
  input  logic                                        clk_i,
  input  logic                                        arst_n_i,
  input  logic                   [NR_FETCH_PORTS-1:0] inst_valid_i,
  input  fetch_pkg::addr_t       [NR_FETCH_PORTS-1:0] inst_addr_i,
  output logic                   [NR_FETCH_PORTS-1:0] inst_ready_o,
  output fetch_pkg::fetch_word_t [NR_FETCH_PORTS-1:0] inst_data_o,
  output logic                   [NR_FETCH_PORTS-1:0] inst_error_o,
  output logic                                        fill_req_valid_o,
  output fetch_pkg::addr_t                            fill_req_addr_o,
  input  logic                                        fill_req_ready_i,
  input  logic                                        fill_rsp_valid_i,
  input  fill_pkg::line_t                             fill_rsp_data_i,
  input  logic                                        fill_rsp_error_i
);

  logic [NR_FETCH_PORTS-1:0] req;
  logic [NR_FETCH_PORTS-1:0] grant;
  logic [NR_FETCH_PORTS-1:0] rsp_hit;
  logic                      push;
  logic                      fifo_full;

  for (genvar i = 0; i < NR_FETCH_PORTS; i++) begin : gen_port
    bypass_port_fsm u_port (
      .clk_i            ( clk_i            ),
      .arst_n_i         ( arst_n_i         ),
      .inst_valid_i     ( inst_valid_i[i]  ),
      .inst_addr_i      ( inst_addr_i[i]   ),
      .grant_i          ( grant[i]         ),
      .fifo_full_i      ( fifo_full        ),
      .rsp_hit_i        ( rsp_hit[i]       ),
      .fill_rsp_data_i  ( fill_rsp_data_i  ),
      .fill_rsp_error_i ( fill_rsp_error_i ),
      .req_o            ( req[i]           ),
      .inst_ready_o     ( inst_ready_o[i]  ),
      .inst_data_o      ( inst_data_o[i]   ),
      .inst_error_o     ( inst_error_o[i]  )
    );
  end

  bypass_req_arbiter #(
    .NR_FETCH_PORTS ( NR_FETCH_PORTS )
  ) u_req_arbiter (
    .clk_i            ( clk_i            ),
    .arst_n_i         ( arst_n_i         ),
    .req_i            ( req              ),
    .inst_addr_i      ( inst_addr_i      ),
    .fill_req_ready_i ( fill_req_ready_i ),
    .grant_o          ( grant            ),
    .fill_req_valid_o ( fill_req_valid_o ),
    .fill_req_addr_o  ( fill_req_addr_o  ),
    .push_o           ( push             )
  );

  // Responses arrive in request order, so the FIFO head owns each one
  bypass_rsp_tracker #(
    .NR_FETCH_PORTS ( NR_FETCH_PORTS ),
    .RSP_FIFO_DEPTH ( RSP_FIFO_DEPTH )
  ) u_rsp_tracker (
    .clk_i            ( clk_i            ),
    .arst_n_i         ( arst_n_i         ),
    .push_i           ( push             ),
    .grant_i          ( grant            ),
    .fill_rsp_valid_i ( fill_rsp_valid_i ),
    .rsp_hit_o        ( rsp_hit          ),
    .full_o           ( fifo_full        )
  );

endmodule

`default_nettype wire

// ==== logic/bypass_rsp_tracker.sv ====
// Response tracker for bypass fills.
// Records the one-hot owner of every accepted fill request in order and
// steers each in-order fill response back to the port at the head.
`default_nettype none

module bypass_rsp_tracker #(
  parameter int unsigned NR_FETCH_PORTS = 4,
  parameter int unsigned RSP_FIFO_DEPTH = 2
) (
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  input  logic                      push_i,
  input  logic [NR_FETCH_PORTS-1:0] grant_i,
  input  logic                      fill_rsp_valid_i,
  output logic [NR_FETCH_PORTS-1:0] rsp_hit_o,
  output logic                      full_o
);

  import fetch_pkg::*;

  localparam int unsigned PtrW = idx_width(RSP_FIFO_DEPTH);
  localparam int unsigned CntW = $clog2(RSP_FIFO_DEPTH + 1);

  logic [NR_FETCH_PORTS-1:0] owner_q [RSP_FIFO_DEPTH];
  logic [PtrW-1:0]           wr_ptr_q;
  logic [PtrW-1:0]           rd_ptr_q;
  logic [CntW-1:0]           count_q;
  logic                      pop;

  // A response with nothing outstanding is dropped
  assign pop       = fill_rsp_valid_i && (count_q != '0);
  assign rsp_hit_o = pop ? owner_q[rd_ptr_q] : '0;
  assign full_o    = (count_q == CntW'(RSP_FIFO_DEPTH));

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      owner_q[wr_ptr_q] <= grant_i;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == PtrW'(RSP_FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrW'(RSP_FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // Simultaneous push and pop leave the count unchanged
      unique case ({push_i, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== logic/bypass_req_arbiter.sv ====
// Round-robin arbiter for bypass fill requests.
// Picks one requesting port, puts its line-aligned address on the fill
// request channel and keeps the choice locked while the fill side stalls.
`default_nettype none

module bypass_req_arbiter #(
  parameter int unsigned NR_FETCH_PORTS = 4
) (
  input  logic                                     clk_i,
  input  logic                                     arst_n_i,
  input  logic             [NR_FETCH_PORTS-1:0]    req_i,
  input  fetch_pkg::addr_t [NR_FETCH_PORTS-1:0]    inst_addr_i,
  input  logic                                     fill_req_ready_i,
  output logic             [NR_FETCH_PORTS-1:0]    grant_o,
  output logic                                     fill_req_valid_o,
  output fetch_pkg::addr_t                         fill_req_addr_o,
  output logic                                     push_o
);

  import fetch_pkg::*;
  import fill_pkg::*;

  localparam int unsigned IdxW = idx_width(NR_FETCH_PORTS);

  logic [IdxW-1:0] rr_q;
  logic [IdxW-1:0] lock_idx_q;
  logic            lock_q;
  logic [IdxW-1:0] search_idx;
  logic [IdxW-1:0] win_idx;
  logic [IdxW-1:0] rr_next;
  logic            found;

  // First requester at or after the priority pointer, wrapping around
  always_comb begin
    int cand;
    search_idx = rr_q;
    found      = 1'b0;
    for (int k = 0; k < NR_FETCH_PORTS; k++) begin
      cand = (int'(rr_q) + k) % NR_FETCH_PORTS;
      if (!found && req_i[cand]) begin
        found      = 1'b1;
        search_idx = IdxW'(cand);
      end
    end
  end

  // A stalled request keeps its winner until the fill side takes it
  assign win_idx          = lock_q ? lock_idx_q : search_idx;
  assign fill_req_valid_o = req_i[win_idx];
  assign push_o           = fill_req_valid_o && fill_req_ready_i;
  assign fill_req_addr_o  = {inst_addr_i[win_idx][FETCH_AW-1:LINE_ALIGN], {LINE_ALIGN{1'b0}}};

  always_comb begin
    for (int k = 0; k < NR_FETCH_PORTS; k++) begin
      grant_o[k] = push_o && (int'(win_idx) == k);
    end
  end

  assign rr_next = IdxW'((int'(win_idx) + 1) % NR_FETCH_PORTS);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rr_q       <= '0;
      lock_q     <= 1'b0;
      lock_idx_q <= '0;
    end else begin
      lock_q <= fill_req_valid_o && !fill_req_ready_i;
      if (fill_req_valid_o && !fill_req_ready_i) begin
        lock_idx_q <= win_idx;
      end
      // Move priority past the port that was just served
      if (push_o) begin
        rr_q <= rr_next;
      end
    end
  end

endmodule

`default_nettype wire

// ==== logic/bypass_port_fsm.sv ====
// Bypass fetch port state machine.
// Takes one fetch at a time, requests its line from the fill side, then
// extracts the fetch word and presents it with the error bit for one cycle.
`default_nettype none

module bypass_port_fsm (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  logic                  inst_valid_i,
  input  fetch_pkg::addr_t      inst_addr_i,
  input  logic                  grant_i,
  input  logic                  fifo_full_i,
  input  logic                  rsp_hit_i,
  input  fill_pkg::line_t       fill_rsp_data_i,
  input  logic                  fill_rsp_error_i,
  output logic                  req_o,
  output logic                  inst_ready_o,
  output fetch_pkg::fetch_word_t inst_data_o,
  output logic                  inst_error_o
);

  import fetch_pkg::*;
  import fill_pkg::*;

  typedef enum logic [1:0] {
    st_idle,
    st_request,
    st_wait,
    st_present
  } state_e;

  state_e state_q;
  state_e state_d;

  logic [WORD_SEL_W-1:0] word_sel;
  fetch_word_t           sel_word;
  fetch_word_t           data_q;
  logic                  error_q;

  // The core holds the address stable for the whole fetch
  assign word_sel = inst_addr_i[LINE_ALIGN-1:FETCH_ALIGN];
  assign sel_word = fill_rsp_data_i[word_sel*FETCH_DW +: FETCH_DW];

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      st_idle: begin
        if (inst_valid_i) begin
          state_d = st_request;
        end
      end
      // Grant only comes back on an accepted fill request
      st_request: begin
        if (grant_i) begin
          state_d = st_wait;
        end
      end
      st_wait: begin
        if (rsp_hit_i) begin
          state_d = st_present;
        end
      end
      st_present: state_d = st_idle;
      default:    state_d = st_idle;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= st_idle;
    end else begin
      state_q <= state_d;
    end
  end

  // Word and error are captured on the response and held through Present
  always_ff @(posedge clk_i) begin
    if (rsp_hit_i) begin
      data_q  <= sel_word;
      error_q <= fill_rsp_error_i;
    end
  end

  // Hold off while the order FIFO has no room left for our response
  assign req_o        = (state_q == st_request) && !fifo_full_i;
  assign inst_ready_o = (state_q == st_present);
  assign inst_data_o  = data_q;
  assign inst_error_o = error_q;

endmodule

`default_nettype wire

// ==== logic/fill_pkg.sv ====
// Fill-side definitions for the uncached instruction-fetch path.
// Describes the line returned by the fill port and how a fetch word is
// located inside it.
`default_nettype none

package fill_pkg;

  localparam int unsigned LINE_WIDTH = 128;

  // Byte-offset bits below one line
  localparam int unsigned LINE_ALIGN = $clog2(LINE_WIDTH / 8);

  // Address bits that pick one fetch word out of a line
  localparam int unsigned WORD_SEL_W = LINE_ALIGN - fetch_pkg::FETCH_ALIGN;

  typedef logic [LINE_WIDTH-1:0] line_t;

endpackage

`default_nettype wire

// ==== logic/fetch_pkg.sv ====
// Fetch-side definitions for the uncached instruction-fetch path.
// Covers the address and instruction word of a fetch port, plus a helper
// that sizes index and pointer fields.
`default_nettype none

package fetch_pkg;

  // Fetch and fill share one address width
  localparam int unsigned FETCH_AW = 32;
  localparam int unsigned FETCH_DW = 32;

  // Byte-offset bits below one fetch word
  localparam int unsigned FETCH_ALIGN = $clog2(FETCH_DW / 8);

  typedef logic [FETCH_AW-1:0] addr_t;
  typedef logic [FETCH_DW-1:0] fetch_word_t;

  // Width of a field that indexes n entries; never narrower than one bit
  function automatic int unsigned idx_width(int unsigned n);
    return (n > 1) ? $clog2(n) : 1;
  endfunction

endpackage

`default_nettype wire
